//--- logic/uart_frame_pkg.sv
// ######################################
// Types for frames delivered by the UART receiver.
// Import it into modules that carry received bytes.
// ######################################
package uart_frame_pkg;

    // Only eight-bit frames are supported.
    localparam int DATA_W = 8;

    // One received frame with its error flags.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              parity_err;  // Parity bit disagreed with the mode.
        logic              frame_err;   // Stop bit was sampled low.
    } uart_rx_result_t;

endpackage

//--- logic/uart_cfg_pkg.sv
// ######################################
// Register map and configuration types of the UART link.
// Shared by the register block, both datapaths and the top.
// ######################################
package uart_cfg_pkg;

    typedef enum logic [1:0] {
        ADDR_DIVISOR = 2'd0,
        ADDR_CTRL    = 2'd1,
        ADDR_STATUS  = 2'd2
    } cfg_addr_t;

    // Control and status bits of a register word.
    typedef struct packed {
        logic [12:0] reserved;  // Reads as zero.
        logic        overrun;
        logic        parity_odd;
        logic        parity_en;
    } cfg_ctrl_t;

    // A register word is a divisor or a control/status word, by address.
    typedef union packed {
        logic [15:0] divisor;
        cfg_ctrl_t   ctrl;
    } cfg_word_u;

    // Live configuration seen by the receiver and the transmitter.
    typedef struct packed {
        logic [15:0] divisor;     // Bit time in clk cycles.
        logic        parity_en;
        logic        parity_odd;
    } uart_cfg_t;

endpackage

//--- logic/uart_cfg_regs.sv
// ######################################
// Configuration and status registers of the UART link.
// Writes land on the next edge, reads are combinational.
// ######################################
`timescale 1ns/1ps

module uart_cfg_regs import uart_cfg_pkg::*; #(
    parameter int unsigned RESET_DIVISOR = 1250
) (
    input  logic      clk,
    input  logic      nRst,
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  cfg_word_u cfg_wdata,
    output cfg_word_u cfg_rdata,
    input  logic      overrun,
    output uart_cfg_t cfg
);

    logic [15:0] divisor_q;
    logic        parity_en_q;
    logic        parity_odd_q;
    logic        overrun_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            divisor_q    <= 16'(RESET_DIVISOR);
            parity_en_q  <= 1'b0;
            parity_odd_q <= 1'b0;
            overrun_q    <= 1'b0;
        end else begin
            if (cfg_we && cfg_addr == ADDR_DIVISOR) begin
                divisor_q <= cfg_wdata.divisor;
            end
            if (cfg_we && cfg_addr == ADDR_CTRL) begin
                parity_en_q  <= cfg_wdata.ctrl.parity_en;
                parity_odd_q <= cfg_wdata.ctrl.parity_odd;
            end
            // A new overrun wins over a clear in the same cycle.
            if (overrun) begin
                overrun_q <= 1'b1;
            end else if (cfg_we && cfg_addr == ADDR_STATUS && cfg_wdata.ctrl.overrun) begin
                overrun_q <= 1'b0;
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            ADDR_DIVISOR: cfg_rdata.divisor = divisor_q;
            ADDR_CTRL: begin
                cfg_rdata.ctrl.parity_en  = parity_en_q;
                cfg_rdata.ctrl.parity_odd = parity_odd_q;
            end
            ADDR_STATUS: cfg_rdata.ctrl.overrun = overrun_q;
            default: cfg_rdata = '0;
        endcase
    end

    assign cfg = '{divisor: divisor_q, parity_en: parity_en_q, parity_odd: parity_odd_q};

endmodule

//--- logic/uart_rx.sv
// ######################################
// UART receiver, 8 data bits, optional parity, one stop bit.
// Frames are released only against credits from the consumer.
// ######################################
`timescale 1ns/1ps

module uart_rx import uart_cfg_pkg::*, uart_frame_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  logic            rx_serial,
    input  uart_cfg_t       cfg,
    input  logic            rx_credit,
    output logic            rx_valid,
    output uart_rx_result_t rx_result,
    output logic            overrun
);

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4,
        CLEAN  = 3'd5
    } rx_state_t;

    rx_state_t         state, next_state;
    logic [15:0]       clk_count, next_clk_count;
    logic [2:0]        bit_index;
    logic [3:0]        ones_count;
    logic              parity_err_q;
    logic [3:0]        credit_q;
    logic [DATA_W-1:0] data_q;
    logic              half_done;
    logic              bit_done;
    logic              stop_sample;

    assign half_done = (clk_count == (cfg.divisor >> 1) - 16'd1);  // Middle of start bit.
    assign bit_done  = (clk_count == cfg.divisor - 16'd1);

    always_comb begin
        next_state     = state;
        next_clk_count = clk_count + 16'd1;
        case (state)
            IDLE: begin
                next_clk_count = '0;
                if (!rx_serial) next_state = START;
            end
            START: begin
                if (half_done) begin
                    next_clk_count = '0;
                    next_state     = rx_serial ? IDLE : DATA;  // Glitch, not a start bit.
                end
            end
            DATA: begin
                if (bit_done) begin
                    next_clk_count = '0;
                    if (bit_index == 3'd7) next_state = cfg.parity_en ? PARITY : STOP;
                end
            end
            PARITY: begin
                if (bit_done) begin
                    next_clk_count = '0;
                    next_state     = STOP;
                end
            end
            STOP: begin
                if (bit_done) begin
                    next_clk_count = '0;
                    next_state     = CLEAN;
                end
            end
            default: begin
                next_clk_count = '0;
                next_state     = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= IDLE;
            clk_count    <= '0;
            bit_index    <= '0;
            ones_count   <= '0;
            parity_err_q <= 1'b0;
        end else begin
            state     <= next_state;
            clk_count <= next_clk_count;
            if (state == START) begin
                bit_index    <= '0;
                ones_count   <= '0;
                parity_err_q <= 1'b0;
            end
            if (state == DATA && bit_done) begin
                bit_index  <= bit_index + 3'd1;
                ones_count <= ones_count + {3'd0, rx_serial};
            end
            // Expected bit makes the total count of ones even, or odd.
            if (state == PARITY && bit_done) begin
                parity_err_q <= rx_serial ^ ones_count[0] ^ cfg.parity_odd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && bit_done) data_q[bit_index] <= rx_serial;
    end

    assign stop_sample = (state == STOP) && bit_done;
    assign rx_valid    = stop_sample && (credit_q != 4'd0);
    assign overrun     = stop_sample && (credit_q == 4'd0);  // No credit, frame dropped.
    assign rx_result   = '{data: data_q, parity_err: parity_err_q, frame_err: ~rx_serial};

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            credit_q <= '0;
        end else if (rx_credit && rx_valid) begin
            credit_q <= credit_q;  // Return and use cancel.
        end else if (rx_credit && credit_q != 4'd15) begin
            credit_q <= credit_q + 4'd1;
        end else if (rx_valid) begin
            credit_q <= credit_q - 4'd1;
        end
    end

endmodule

//--- logic/uart_tx.sv
// ######################################
// UART transmitter with a one-byte holding register.
// Hands the host one credit per frame it can accept.
// ######################################
`timescale 1ns/1ps

module uart_tx import uart_cfg_pkg::*; (
    input  logic      clk,
    input  logic      nRst,
    input  uart_cfg_t cfg,
    input  logic      tx_valid,
    input  logic [7:0] tx_data,
    output logic      tx_credit,
    output logic      tx_serial
);

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4
    } tx_state_t;

    tx_state_t   state;
    logic [15:0] clk_count;
    logic [2:0]  bit_index;
    logic        init_done;
    logic [7:0]  shift_q;
    logic        parity_q;
    logic        bit_done;
    logic        load;

    assign bit_done = (clk_count == cfg.divisor - 16'd1);
    assign load     = (state == IDLE) && tx_valid;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            clk_count <= '0;
            bit_index <= '0;
            tx_serial <= 1'b1;
            tx_credit <= 1'b0;
            init_done <= 1'b0;
        end else begin
            tx_credit <= !init_done;  // First credit after reset.
            init_done <= 1'b1;
            clk_count <= bit_done ? 16'd0 : clk_count + 16'd1;
            case (state)
                IDLE: begin
                    clk_count <= '0;
                    if (tx_valid) begin
                        state     <= START;
                        tx_serial <= 1'b0;
                    end
                end
                START: begin
                    if (bit_done) begin
                        state     <= DATA;
                        bit_index <= '0;
                        tx_serial <= shift_q[0];
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        bit_index <= bit_index + 3'd1;
                        if (bit_index != 3'd7) begin
                            tx_serial <= shift_q[1];  // Next LSB after the shift.
                        end else if (cfg.parity_en) begin
                            state     <= PARITY;
                            tx_serial <= parity_q;
                        end else begin
                            state     <= STOP;
                            tx_serial <= 1'b1;
                        end
                    end
                end
                PARITY: begin
                    if (bit_done) begin
                        state     <= STOP;
                        tx_serial <= 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state     <= IDLE;
                        tx_credit <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q  <= tx_data;
            parity_q <= ^tx_data ^ cfg.parity_odd;
        end else if (state == DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

//--- logic/uart_link_top.sv
// ######################################
// UART link top: register block, receiver and transmitter.
// ######################################
`timescale 1ns/1ps

module uart_link_top import uart_cfg_pkg::*, uart_frame_pkg::*; #(
    parameter int unsigned RESET_DIVISOR = 1250
) (
    input  logic            clk,
    input  logic            nRst,
    input  logic            cfg_we,
    input  cfg_addr_t       cfg_addr,
    input  cfg_word_u       cfg_wdata,
    output cfg_word_u       cfg_rdata,
    input  logic            rx_serial,
    input  logic            rx_credit,
    output logic            rx_valid,
    output uart_rx_result_t rx_result,
    input  logic            tx_valid,
    input  logic [7:0]      tx_data,
    output logic            tx_credit,
    output logic            tx_serial
);

    uart_cfg_t cfg;
    logic      overrun;  // One-cycle pulse from the receiver.

    uart_cfg_regs #(
        .RESET_DIVISOR(RESET_DIVISOR)
    ) u_cfg_regs (
        .clk       (clk),
        .nRst      (nRst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .overrun   (overrun),
        .cfg       (cfg)
    );

    uart_rx u_rx (
        .clk       (clk),
        .nRst      (nRst),
        .rx_serial (rx_serial),
        .cfg       (cfg),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_result (rx_result),
        .overrun   (overrun)
    );

    uart_tx u_tx (
        .clk       (clk),
        .nRst      (nRst),
        .cfg       (cfg),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .tx_serial (tx_serial)
    );

endmodule

//--- dv/uart_link_tb.sv
// ######################################
// Directed testbench for the UART link top.
// Covers registers, loopback, injected errors and receive credits.
// ######################################
`timescale 1ns/1ps

module uart_link_tb import uart_cfg_pkg::*, uart_frame_pkg::*; ;

    localparam int DIV            = 16;
    localparam int N_FRAMES       = 22;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 12 * DIV + 2000;

    logic            clk;
    logic            nRst;
    logic            cfg_we;
    cfg_addr_t       cfg_addr;
    cfg_word_u       cfg_wdata;
    cfg_word_u       cfg_rdata;
    logic            rx_serial;
    logic            rx_credit;
    logic            rx_valid;
    uart_rx_result_t rx_result;
    logic            tx_valid;
    logic [7:0]      tx_data;
    logic            tx_credit;
    logic            tx_serial;

    logic            loopback;  // Selects tx_serial or the bit-banged line.
    logic            line_q;
    integer          seed = 32'h6d1b_9d43;
    int              value_errors = 0;
    int              other_errors = 0;
    int              cycle_count = 0;
    int              tx_credits = 0;
    int              tx_credit_total = 0;
    uart_rx_result_t rx_q[$];

    assign rx_serial = loopback ? tx_serial : line_q;

    uart_link_top dut (
        .clk       (clk),
        .nRst      (nRst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .rx_serial (rx_serial),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_result (rx_result),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .tx_serial (tx_serial)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Collects received frames and transmit credits.
    always @(negedge clk) begin
        if (nRst) begin
            if (rx_valid) rx_q.push_back(rx_result);
            if (tx_credit) begin
                if (tx_credits != 0) begin
                    other_errors++;
                    $display("A second tx credit arrived at %0d ns before the first was used",
                             $time);
                end
                tx_credits++;
                tx_credit_total++;
            end
        end
    end

    function automatic cfg_word_u make_ctrl(input logic en, input logic odd, input logic ovr);
        cfg_word_u w;
        w = '0;
        w.ctrl.parity_en  = en;
        w.ctrl.parity_odd = odd;
        w.ctrl.overrun    = ovr;
        return w;
    endfunction

    function automatic cfg_word_u make_divisor(input logic [15:0] value);
        cfg_word_u w;
        w.divisor = value;
        return w;
    endfunction

    // A forced error flips the parity bit, so it only counts with parity on.
    function automatic uart_rx_result_t expect_result(input logic [7:0] d, input logic par_en,
                                                      input logic force_err, input logic stop);
        uart_rx_result_t r;
        r.data       = d;
        r.parity_err = par_en & force_err;
        r.frame_err  = ~stop;
        return r;
    endfunction

    task automatic check_result(input uart_rx_result_t got, input uart_rx_result_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s got data %h pe %b fe %b, expected data %h pe %b fe %b",
                     $time, what, got.data, got.parity_err, got.frame_err,
                     exp.data, exp.parity_err, exp.frame_err);
        end
    endtask

    task automatic check_cfg(input cfg_word_u got, input cfg_word_u exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_word_u word);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = word;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic read_check(input cfg_addr_t addr, input cfg_word_u exp, input string what);
        @(posedge clk);
        #1;
        cfg_addr = addr;
        @(negedge clk);
        check_cfg(cfg_rdata, exp, what);
    endtask

    task automatic grant_rx_credit();
        @(posedge clk);
        #1;
        rx_credit = 1'b1;
        @(posedge clk);
        #1;
        rx_credit = 1'b0;
    endtask

    task automatic wait_tx_credit();
        do @(posedge clk); while (tx_credits == 0);
    endtask

    // Sends one byte through the transmitter and checks what comes back.
    task automatic loop_frame(input logic [7:0] d, input logic par_en);
        wait_tx_credit();
        #1;
        tx_credits--;
        tx_valid  = 1'b1;
        tx_data   = d;
        rx_credit = 1'b1;
        @(posedge clk);
        #1;
        tx_valid  = 1'b0;
        rx_credit = 1'b0;
        while (rx_q.size() == 0) @(negedge clk);
        check_result(rx_q.pop_front(), expect_result(d, par_en, 1'b0, 1'b1), "loopback frame");
    endtask

    task automatic drive_bit(input logic b);
        line_q = b;
        repeat (DIV) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] d, input logic par_en, input logic par_odd,
                              input logic force_err, input logic stop);
        @(posedge clk);
        #1;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) drive_bit(d[i]);
        if (par_en) drive_bit(^d ^ par_odd ^ force_err);
        drive_bit(stop);
        drive_bit(1'b1);  // Two idle bit times.
        drive_bit(1'b1);
    endtask

    task automatic expect_frames(input int n, input string what);
        if (rx_q.size() != n) begin
            other_errors++;
            $display("Expected %0d received frames after %s but saw %0d", n, what, rx_q.size());
        end
    endtask

    task automatic test_registers();
        read_check(ADDR_DIVISOR, make_divisor(16'd1250), "reset divisor");
        read_check(ADDR_STATUS, make_ctrl(1'b0, 1'b0, 1'b0), "reset status");
        write_reg(ADDR_DIVISOR, make_divisor(16'(DIV)));
        read_check(ADDR_DIVISOR, make_divisor(16'(DIV)), "divisor");
        write_reg(ADDR_CTRL, make_ctrl(1'b1, 1'b1, 1'b0));
        read_check(ADDR_CTRL, make_ctrl(1'b1, 1'b1, 1'b0), "control");
        write_reg(ADDR_CTRL, make_ctrl(1'b0, 1'b0, 1'b0));
        read_check(ADDR_CTRL, make_ctrl(1'b0, 1'b0, 1'b0), "control cleared");
    endtask

    task automatic test_loopback_plain();
        for (int i = 0; i < 8; i++) loop_frame(8'($random(seed)), 1'b0);
        wait_tx_credit();
        if (tx_credit_total != 9) begin
            other_errors++;
            $display("Counted %0d tx credits for 8 frames, expected 9", tx_credit_total);
        end
    endtask

    task automatic test_loopback_parity();
        write_reg(ADDR_CTRL, make_ctrl(1'b1, 1'b0, 1'b0));
        for (int i = 0; i < 4; i++) loop_frame(8'($random(seed)), 1'b1);
        wait_tx_credit();
        write_reg(ADDR_CTRL, make_ctrl(1'b1, 1'b1, 1'b0));
        for (int i = 0; i < 4; i++) loop_frame(8'($random(seed)), 1'b1);
        wait_tx_credit();
    endtask

    task automatic test_injected_errors();
        logic [7:0] d;
        loopback = 1'b0;
        write_reg(ADDR_CTRL, make_ctrl(1'b1, 1'b0, 1'b0));
        d = 8'($random(seed));
        grant_rx_credit();
        send_frame(d, 1'b1, 1'b0, 1'b1, 1'b1);
        expect_frames(1, "bad parity frame");
        if (rx_q.size() != 0) check_result(rx_q.pop_front(), expect_result(d, 1'b1, 1'b1, 1'b1),
                                           "bad parity frame");
        d = 8'($random(seed));
        grant_rx_credit();
        send_frame(d, 1'b1, 1'b0, 1'b0, 1'b0);
        expect_frames(1, "low stop bit frame");
        if (rx_q.size() != 0) check_result(rx_q.pop_front(), expect_result(d, 1'b1, 1'b0, 1'b0),
                                           "low stop bit frame");
    endtask

    task automatic test_rx_credits();
        write_reg(ADDR_CTRL, make_ctrl(1'b0, 1'b0, 1'b0));
        send_frame(8'($random(seed)), 1'b0, 1'b0, 1'b0, 1'b1);
        expect_frames(0, "a frame without credit");
        read_check(ADDR_STATUS, make_ctrl(1'b0, 1'b0, 1'b1), "status after drop");
        write_reg(ADDR_STATUS, make_ctrl(1'b0, 1'b0, 1'b1));
        read_check(ADDR_STATUS, make_ctrl(1'b0, 1'b0, 1'b0), "status after clear");
        grant_rx_credit();
        grant_rx_credit();
        for (int i = 0; i < 2; i++) begin
            logic [7:0] d;
            d = 8'($random(seed));
            send_frame(d, 1'b0, 1'b0, 1'b0, 1'b1);
            expect_frames(1, "a credited frame");
            if (rx_q.size() != 0) check_result(rx_q.pop_front(),
                                               expect_result(d, 1'b0, 1'b0, 1'b1), "credited frame");
        end
        send_frame(8'($random(seed)), 1'b0, 1'b0, 1'b0, 1'b1);
        expect_frames(0, "a third frame without credit");
        read_check(ADDR_STATUS, make_ctrl(1'b0, 1'b0, 1'b1), "status after second drop");
    endtask

    initial begin
        nRst      = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = ADDR_DIVISOR;
        cfg_wdata = '0;
        rx_credit = 1'b0;
        tx_valid  = 1'b0;
        tx_data   = '0;
        loopback  = 1'b1;
        line_q    = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        nRst = 1'b1;
        test_registers();
        test_loopback_plain();
        test_loopback_parity();
        test_injected_errors();
        test_rx_credits();
        $display("Finished with %0d value errors and %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- uart_link.f
logic/uart_frame_pkg.sv
logic/uart_cfg_pkg.sv
logic/uart_cfg_regs.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_link_top.sv
dv/uart_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the UART link testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module uart_link_tb \
    -f uart_link.f --Mdir obj_dir -o uart_link_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/uart_link_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$SIM_LOG"
    echo "Simulation exited with an error, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"
if grep -q "^SIMULATION PASSED$" "$SIM_LOG"; then
    exit 0
fi
exit 1
